/* include/dmem_settings.svh */
// data memory settings, sizes shared by the packages and the RTL
`ifndef DMEM_SETTINGS_SVH
`define DMEM_SETTINGS_SVH

// byte address bits, 4096 bytes in total
`define DMEM_ADDR_WIDTH 12

// data word width seen by the cpu
`define DMEM_WORD_WIDTH 32

// byte lanes per word, one bank each
`define DMEM_LANES 4

`endif

/* design/dmem_access_pkg.sv */
// data memory access package, operation codes and byte address layout
`include "dmem_settings.svh"

package dmem_access_pkg;

    // load and store operations
    typedef enum logic [2:0] {
        OP_LW  = 3'd0,  // load word
        OP_LB  = 3'd1,  // load byte, sign extended
        OP_LBU = 3'd2,  // load byte, zero extended
        OP_SW  = 3'd4,  // store word
        OP_SB  = 3'd5   // store byte
    } dmem_op_e;

    // byte address, word index on top and lane offset below
    typedef struct packed {
        logic [`DMEM_ADDR_WIDTH-3:0] index;
        logic [1:0]                  offset;
    } dmem_addr_t;

endpackage

/* design/dmem_data_pkg.sv */
// data memory data package, word and byte lane views of one data word
`include "dmem_settings.svh"

package dmem_data_pkg;

    // lane 0 is the least significant byte
    typedef union packed {
        logic [`DMEM_WORD_WIDTH-1:0]     word;
        logic [`DMEM_LANES-1:0][7:0]     bytes;
    } dmem_word_u;

endpackage

/* design/dmem_request_decoder.sv */
// request decoder, runs the req/ack handshake and drives the byte lanes
`timescale 1ns/100ps
`include "dmem_settings.svh"

module dmem_request_decoder
    import dmem_access_pkg::*;
    import dmem_data_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              req,
    input  dmem_op_e                          op,
    input  dmem_addr_t                        addr,
    input  dmem_word_u                        wdata,
    output logic                              ack,
    output logic                              err,
    output logic [`DMEM_LANES-1:0]            lane_en,
    output logic [`DMEM_LANES-1:0]            lane_we,
    output logic [`DMEM_ADDR_WIDTH-3:0]       lane_index,
    output logic [`DMEM_LANES-1:0][7:0]       lane_wbyte,
    output dmem_op_e                          acc_op,
    output logic [1:0]                        acc_offset
);

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_ACCESS = 2'd1;  // lanes enabled this cycle
    localparam logic [1:0] S_ACK    = 2'd2;

    logic [1:0]             state;
    logic                   acc_bad;    // refused word access
    logic                   word_op;
    logic                   store_op;
    logic                   misaligned;
    logic [`DMEM_LANES-1:0] lane_mask;
    logic                   accept;

    always_comb begin
        word_op    = (op == OP_LW) || (op == OP_SW);
        store_op   = (op == OP_SW) || (op == OP_SB);
        misaligned = word_op && (addr.offset != 2'b00);
        if (misaligned) begin
            lane_mask = '0;  // nothing touched
        end else if (word_op) begin
            lane_mask = '1;
        end else begin
            lane_mask = `DMEM_LANES'(1) << addr.offset;
        end
    end

    assign accept = (state == S_IDLE) && req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            lane_en    <= '0;
            lane_we    <= '0;
            acc_op     <= OP_LW;
            acc_offset <= 2'b00;
            acc_bad    <= 1'b0;
        end else begin
            lane_en <= '0;  // enables last one cycle only
            lane_we <= '0;
            case (state)
                S_IDLE: begin
                    if (req) begin
                        state      <= S_ACCESS;
                        lane_en    <= lane_mask;
                        lane_we    <= store_op ? lane_mask : '0;
                        acc_op     <= op;
                        acc_offset <= addr.offset;
                        acc_bad    <= misaligned;
                    end
                end
                S_ACCESS: state <= S_ACK;
                S_ACK: begin
                    if (!req) begin
                        state <= S_IDLE;  // wait for req low before next access
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // write bytes and word index, captured with the access
    always_ff @(posedge clk) begin
        if (accept) begin
            lane_index <= addr.index;
            for (int i = 0; i < `DMEM_LANES; i++) begin
                // byte stores take the low byte on every lane
                lane_wbyte[i] <= (op == OP_SB) ? wdata.bytes[0] : wdata.bytes[i];
            end
        end
    end

    assign ack = (state == S_ACK);
    assign err = ack && acc_bad;  // falls together with ack

endmodule

/* design/dmem_byte_bank.sv */
// byte bank, one lane of storage with synchronous write and registered read
`timescale 1ns/100ps
`include "dmem_settings.svh"

module dmem_byte_bank (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        en,
    input  logic                        we,
    input  logic [`DMEM_ADDR_WIDTH-3:0] index,
    input  logic [7:0]                  wbyte,
    output logic [7:0]                  rbyte
);

    localparam int DEPTH = 2 ** (`DMEM_ADDR_WIDTH - 2);

    logic [7:0] mem [DEPTH];  // contents start undefined

    always_ff @(posedge clk) begin
        if (en && we) begin
            mem[index] <= wbyte;
        end
    end

    // read byte holds until the next read of this lane
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rbyte <= 8'h00;
        end else if (en && !we) begin
            rbyte <= mem[index];
        end
    end

endmodule

/* design/dmem_load_aligner.sv */
// load aligner, builds rdata from the lane bytes with byte select and extension
`timescale 1ns/100ps
`include "dmem_settings.svh"

module dmem_load_aligner
    import dmem_access_pkg::*;
    import dmem_data_pkg::*;
(
    input  logic [`DMEM_LANES-1:0][7:0]  lane_rbyte,
    input  dmem_op_e                     acc_op,
    input  logic [1:0]                   acc_offset,
    output logic [`DMEM_WORD_WIDTH-1:0]  rdata
);

    dmem_word_u lanes;
    logic [7:0] sel_byte;

    always_comb begin
        lanes.bytes = lane_rbyte;
        sel_byte    = lanes.bytes[acc_offset];  // byte picked by offset
        case (acc_op)
            OP_LB:   rdata = {{(`DMEM_WORD_WIDTH-8){sel_byte[7]}}, sel_byte};
            OP_LBU:  rdata = {{(`DMEM_WORD_WIDTH-8){1'b0}}, sel_byte};
            // word loads, and stores which just show the last lane bytes
            default: rdata = lanes.word;
        endcase
    end

endmodule

/* design/data_mem_top.sv */
// data memory top, decoder feeding four byte banks drained by the load aligner
`timescale 1ns/100ps
`include "dmem_settings.svh"

module data_mem_top
    import dmem_access_pkg::*;
    import dmem_data_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req,
    input  dmem_op_e                    op,
    input  dmem_addr_t                  addr,
    input  dmem_word_u                  wdata,
    output logic                        ack,
    output logic                        err,
    output logic [`DMEM_WORD_WIDTH-1:0] rdata
);

    logic [`DMEM_LANES-1:0]       lane_en;
    logic [`DMEM_LANES-1:0]       lane_we;
    logic [`DMEM_ADDR_WIDTH-3:0]  lane_index;  // same word index on every lane
    logic [`DMEM_LANES-1:0][7:0]  lane_wbyte;
    logic [`DMEM_LANES-1:0][7:0]  lane_rbyte;
    dmem_op_e                     acc_op;
    logic [1:0]                   acc_offset;

    dmem_request_decoder i_dmem_request_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .op         (op),
        .addr       (addr),
        .wdata      (wdata),
        .ack        (ack),
        .err        (err),
        .lane_en    (lane_en),
        .lane_we    (lane_we),
        .lane_index (lane_index),
        .lane_wbyte (lane_wbyte),
        .acc_op     (acc_op),
        .acc_offset (acc_offset)
    );

    for (genvar g = 0; g < `DMEM_LANES; g++) begin : g_lane
        dmem_byte_bank i_dmem_byte_bank (
            .clk   (clk),
            .rst_n (rst_n),
            .en    (lane_en[g]),
            .we    (lane_we[g]),
            .index (lane_index),
            .wbyte (lane_wbyte[g]),
            .rbyte (lane_rbyte[g])
        );
    end

    dmem_load_aligner i_dmem_load_aligner (
        .lane_rbyte (lane_rbyte),
        .acc_op     (acc_op),
        .acc_offset (acc_offset),
        .rdata      (rdata)
    );

endmodule

/* tests/tb_clock_gen.sv */
// testbench clock and reset, free running clock with reset held at start
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);  // release away from the sampling edge
        rst_n = 1'b1;
    end

endmodule

/* tests/data_mem_asserts.sv */
// handshake and err assertions bound into the data memory top level
`timescale 1ns/100ps

module data_mem_asserts
    import dmem_access_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       req,
    input dmem_op_e   op,
    input dmem_addr_t addr,
    input logic       ack,
    input logic       err
);

    int   fail_count = 0;  // assertion failures so far
    logic refused;

    // word access off a word boundary
    assign refused = (op == OP_LW || op == OP_SW) && (addr.offset != 2'b00);

    // ack only rises on an edge that saw req high
    ack_rise_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
    else begin
        fail_count++;
        $error("ack rose without req high");
    end

    ack_held_with_req: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ack) |-> !$past(req))
    else begin
        fail_count++;
        $error("ack fell while req was still high");
    end

    // err comes with an ack exactly when the request was refused
    err_marks_refused: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> (err == $past(refused)))
    else begin
        fail_count++;
        $error("err does not match the refusal of the access");
    end

endmodule

bind data_mem_top data_mem_asserts i_data_mem_asserts (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .op    (op),
    .addr  (addr),
    .ack   (ack),
    .err   (err)
);

/* tests/data_mem_tb.sv */
// data memory testbench, directed and random accesses checked against a byte model
`timescale 1ns/100ps
`include "dmem_settings.svh"

module data_mem_tb
    import dmem_access_pkg::*;
    import dmem_data_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 10;
    localparam int DIRECTED_TXN = 27;
    localparam int RANDOM_TXN   = 300;
    localparam int TXN_CYCLES   = 20;   // generous bound per transaction
    localparam int AW           = `DMEM_ADDR_WIDTH;
    localparam int MEM_BYTES    = 2 ** AW;
    localparam int WATCHDOG_NS  =
        ((DIRECTED_TXN + RANDOM_TXN) * TXN_CYCLES + RESET_CYCLES + 4) * CLK_PERIOD;

    typedef struct packed {
        dmem_op_e    op;
        logic [AW-1:0] addr;
        logic [31:0] rdata;
        logic        err;
        logic        chk;  // rdata is known and must match
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        req;
    dmem_op_e    op;
    dmem_addr_t  addr;
    dmem_word_u  wdata;
    logic        ack;
    logic        err;
    logic [31:0] rdata;

    logic [7:0]  ref_mem     [MEM_BYTES];
    bit          ref_written [MEM_BYTES];
    expect_t     exp_q [$];
    int unsigned lcg_state    = 95593;
    int          data_errors  = 0;
    int          proto_errors = 0;

    tb_clock_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) i_tb_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    data_mem_top i_data_mem_top (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .op    (op),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .err   (err),
        .rdata (rdata)
    );

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;  // low bits of an lcg cycle quickly
    endfunction

    // expected response of one access, from the model before the access
    function automatic void ref_access(input dmem_op_e a_op, input logic [AW-1:0] a_addr,
                                       output logic [31:0] e_rdata, output logic e_err,
                                       output logic e_chk);
        logic [AW-1:0] base;
        logic [7:0]    b;
        base    = {a_addr[AW-1:2], 2'b00};
        b       = ref_mem[a_addr];
        e_rdata = '0;
        e_err   = 1'b0;
        e_chk   = 1'b0;
        if ((a_op == OP_LW || a_op == OP_SW) && a_addr[1:0] != 2'b00) begin
            e_err = 1'b1;  // refused
        end else if (a_op == OP_LW) begin
            e_rdata = {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
            e_chk   = ref_written[base] && ref_written[base + 1] &&
                      ref_written[base + 2] && ref_written[base + 3];
        end else if (a_op == OP_LB) begin
            e_rdata = {{24{b[7]}}, b};
            e_chk   = ref_written[a_addr];
        end else if (a_op == OP_LBU) begin
            e_rdata = {24'h000000, b};
            e_chk   = ref_written[a_addr];
        end
    endfunction

    task automatic update_model(input dmem_op_e a_op, input logic [AW-1:0] a_addr,
                                input logic [31:0] a_data);
        if (a_op == OP_SW && a_addr[1:0] == 2'b00) begin
            for (int i = 0; i < 4; i++) begin
                ref_mem[a_addr + i]     = a_data[8*i +: 8];
                ref_written[a_addr + i] = 1'b1;
            end
        end else if (a_op == OP_SB) begin
            ref_mem[a_addr]     = a_data[7:0];
            ref_written[a_addr] = 1'b1;
        end
    endtask

    // one four-phase transaction, entered and left 10 ns after a rising edge
    task automatic run_access(input dmem_op_e a_op, input logic [AW-1:0] a_addr,
                              input logic [31:0] a_data);
        expect_t     e;
        logic [31:0] e_rdata;
        logic        e_err;
        logic        e_chk;
        int          edges;
        int          hold;
        ref_access(a_op, a_addr, e_rdata, e_err, e_chk);
        e.op    = a_op;
        e.addr  = a_addr;
        e.rdata = e_rdata;
        e.err   = e_err;
        e.chk   = e_chk;
        exp_q.push_back(e);
        update_model(a_op, a_addr, a_data);
        req        = 1'b1;
        op         = a_op;
        addr       = a_addr;
        wdata.word = a_data;
        edges      = 0;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
            edges++;
        end while (!ack && edges < 10);
        if (!ack) begin
            $display("no acknowledge from the DUT for %s at address %h", a_op.name(), a_addr);
            proto_errors++;
            void'(exp_q.pop_back());
            req = 1'b0;
            return;
        end
        if (edges != 2) begin
            $display("ERR %0t: ack after %0d edges, expected 2", $time, edges);
            proto_errors++;
        end
        hold = lcg_next() % 4;
        repeat (hold) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (!ack) begin
                $display("ERR %0t: ack dropped while req held high", $time);
                proto_errors++;
            end
        end
        req   = 1'b0;
        edges = 0;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
            edges++;
        end while (ack && edges < 10);
        if (ack) begin
            $display("ack stayed high long after req fell at address %h", a_addr);
            proto_errors++;
        end else if (edges != 1) begin
            $display("ERR %0t: ack fell %0d edges after req, expected 1", $time, edges);
            proto_errors++;
        end
    endtask

    // compare at each rising ack
    initial begin
        expect_t e;
        forever begin
            @(posedge ack);
            #1;
            if (exp_q.size() == 0) begin
                $display("acknowledge seen with no access outstanding");
                proto_errors++;
            end else begin
                e = exp_q.pop_front();
                if (err !== e.err) begin
                    $display("ERR %0t: %s at %h err %b, expected %b",
                             $time, e.op.name(), e.addr, err, e.err);
                    data_errors++;
                end
                if (e.chk && rdata !== e.rdata) begin
                    $display("ERR %0t: %s at %h rdata %h, expected %h",
                             $time, e.op.name(), e.addr, rdata, e.rdata);
                    data_errors++;
                end
            end
        end
    end

    initial begin
        #WATCHDOG_NS;
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        dmem_op_e      rop;
        logic [AW-1:0] raddr;
        logic [31:0]   rdat;
        int            total;
        req   = 1'b0;
        op    = OP_LW;
        addr  = '0;
        wdata = '0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (ack !== 1'b0 || err !== 1'b0) begin
                $display("ERR %0t: ack or err not low during reset", $time);
                proto_errors++;
            end
        end

        // word round trips, including the last word
        run_access(OP_SW, 12'h100, 32'hDEADBEEF);
        run_access(OP_LW, 12'h100, 32'h0);
        run_access(OP_SW, 12'hFFC, 32'h12345678);
        run_access(OP_LW, 12'hFFC, 32'h0);

        // byte stores with junk in the upper wdata bytes
        for (int i = 0; i < 4; i++) begin
            run_access(OP_SB, 12'h200 + i, 32'hA5A5A500 | (32'h11 * (i + 1)));
        end
        run_access(OP_LW, 12'h200, 32'h0);

        run_access(OP_SW, 12'h300, 32'h01FF7F80);
        for (int i = 0; i < 4; i++) begin
            run_access(OP_LB, 12'h300 + i, 32'h0);
            run_access(OP_LBU, 12'h300 + i, 32'h0);
        end

        // misaligned word accesses are refused and leave memory alone
        run_access(OP_SW, 12'h400, 32'hCAFEF00D);
        for (int i = 1; i < 4; i++) begin
            run_access(OP_SW, 12'h400 + i, 32'h0BADBEEF);
        end
        run_access(OP_LW, 12'h400, 32'h0);
        for (int i = 1; i < 4; i++) begin
            run_access(OP_LW, 12'h400 + i, 32'h0);
        end
        run_access(OP_LW, 12'h400, 32'h0);

        for (int n = 0; n < RANDOM_TXN; n++) begin
            case (lcg_next() % 5)
                0:       rop = OP_LW;
                1:       rop = OP_LB;
                2:       rop = OP_LBU;
                3:       rop = OP_SW;
                default: rop = OP_SB;
            endcase
            raddr = 12'h600 + (lcg_next() % 128);  // small window so loads hit stores
            if ((rop == OP_LW || rop == OP_SW) && (lcg_next() % 8) != 0) begin
                raddr[1:0] = 2'b00;
            end
            rdat = (lcg_next() << 16) ^ lcg_next();
            run_access(rop, raddr, rdat);
        end

        if (exp_q.size() != 0) begin
            $display("%0d expected responses were never checked", exp_q.size());
            proto_errors++;
        end
        total = data_errors + proto_errors + i_data_mem_top.i_data_mem_asserts.fail_count;
        $display("errors: data %0d, handshake %0d, assertions %0d", data_errors, proto_errors,
                 i_data_mem_top.i_data_mem_asserts.fail_count);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
design/dmem_access_pkg.sv
design/dmem_data_pkg.sv
design/dmem_request_decoder.sv
design/dmem_byte_bank.sv
design/dmem_load_aligner.sv
design/data_mem_top.sv
tests/tb_clock_gen.sv
tests/data_mem_asserts.sv
tests/data_mem_tb.sv

/* Bender.yml */
package:
  name: data_mem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/dmem_access_pkg.sv
      - design/dmem_data_pkg.sv
      - design/dmem_request_decoder.sv
      - design/dmem_byte_bank.sv
      - design/dmem_load_aligner.sv
      - design/data_mem_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_clock_gen.sv
      - tests/data_mem_asserts.sv
      - tests/data_mem_tb.sv
